// File: design/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

    localparam int addr_bits   = 32;
    localparam int data_bits   = 64;
    localparam int seg_bits    = 16;
    localparam int eip_bits    = 32;
    localparam int imm_bits    = 48;
    localparam int ctrl_bits   = 16;
    localparam int op_count    = 4;

    localparam int line_count  = 16;
    localparam int index_bits  = 4;
    localparam int offset_bits = 3;                                    // byte in word, ignored
    localparam int tag_bits    = addr_bits - index_bits - offset_bits; // addr 31:7

    typedef logic [1:0] size_t;

    localparam size_t size_byte  = 2'd0;
    localparam size_t size_word  = 2'd1;
    localparam size_t size_dword = 2'd2;
    localparam size_t size_qword = 2'd3;

    typedef logic [3:0] src_t;

    localparam src_t src_reg0 = 4'd0;
    localparam src_t src_reg3 = 4'd3;
    localparam src_t src_seg0 = 4'd4;
    localparam src_t src_seg3 = 4'd7;
    localparam src_t src_mem  = 4'd8;
    localparam src_t src_eip  = 4'd9;
    localparam src_t src_imm  = 4'd10; // 11..15 read as zero

    typedef logic [op_count-1:0][data_bits-1:0] ops_t;

    typedef struct packed {
        ops_t                              regs;
        logic [op_count-1:0][seg_bits-1:0] segs;
        logic [addr_bits-1:0]              mem_addr;
        logic                              mem_rd;
        logic [eip_bits-1:0]               eip;
        logic [imm_bits-1:0]               imm;
        src_t [op_count-1:0]               src;
        size_t                             opsize;
        logic [3:0]                        size_ovr; // one-hot, zero means opsize
        logic [ctrl_bits-1:0]              ctrl;
    } uop_t;

    typedef struct packed {
        logic [addr_bits-1:0] addr;
        logic                 valid;
    } cache_req_t;

    typedef struct packed {
        ops_t                 ops;
        size_t                size;
        logic [data_bits-1:0] mem_data;
        logic [ctrl_bits-1:0] ctrl;
    } stage_out_t;

    typedef struct packed {
        logic [addr_bits-1:0] addr;
        logic [data_bits-1:0] data;
        logic                 valid;
    } wb_t;

    // keep only the low bytes of a loaded word
    function automatic logic [data_bits-1:0] mask_to_size(
        input logic [data_bits-1:0] data,
        input size_t                size
    );
        logic [data_bits-1:0] mask;
        case (size)
            size_byte:  mask = 64'h0000_0000_0000_00ff;
            size_word:  mask = 64'h0000_0000_0000_ffff;
            size_dword: mask = 64'h0000_0000_ffff_ffff;
            size_qword: mask = 64'hffff_ffff_ffff_ffff;
            default:    mask = '0;
        endcase
        return data & mask;
    endfunction

endpackage

`default_nettype wire

// File: design/stage_reg.sv
`timescale 1ns/10ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           en,
    input  wire           d_valid,
    input  wire payload_t d,
    output logic          q_valid,
    output payload_t      q
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_valid <= 1'b0;
        end else if (en) begin
            q_valid <= d_valid;
        end
    end

    // payload follows the enable only
    always_ff @(posedge clk) begin
        if (en) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// File: design/dcache_read.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_read (
    input  wire                                       clk,
    input  wire                                       rst_n,
    input  wire mem_stage_pkg::cache_req_t            req,
    input  wire mem_stage_pkg::wb_t                   wb,
    input  wire                                       fill_valid,
    input  wire [mem_stage_pkg::data_bits-1:0]        fill_data,
    output logic                                      hit,
    output logic [mem_stage_pkg::data_bits-1:0]       rd_data,
    output logic                                      miss_req,
    output logic [mem_stage_pkg::addr_bits-1:0]       miss_addr
);
    import mem_stage_pkg::*;

    logic [tag_bits-1:0]   tag_mem  [line_count];
    logic [data_bits-1:0]  data_mem [line_count];
    logic [line_count-1:0] line_valid;

    logic [index_bits-1:0] rd_idx;
    logic [index_bits-1:0] wb_idx;
    logic [index_bits-1:0] fill_idx;
    logic [tag_bits-1:0]   rd_tag;
    logic [tag_bits-1:0]   wb_tag;
    logic                  wb_hit;
    logic                  fill_we;
    logic                  miss_en;
    cache_req_t            miss_d;
    cache_req_t            miss_q;

    assign rd_idx   = req.addr[offset_bits +: index_bits];
    assign rd_tag   = req.addr[addr_bits-1 -: tag_bits];
    assign wb_idx   = wb.addr[offset_bits +: index_bits];
    assign wb_tag   = wb.addr[addr_bits-1 -: tag_bits];
    assign fill_idx = miss_addr[offset_bits +: index_bits];

    assign hit     = req.valid && line_valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign rd_data = data_mem[rd_idx];

    assign wb_hit  = wb.valid && line_valid[wb_idx] && (tag_mem[wb_idx] == wb_tag);
    assign fill_we = fill_valid && miss_req; // stray fills are dropped

    // open a miss on a fresh lookup failure, close it on the fill
    assign miss_en = (req.valid && !hit && !miss_req) || fill_we;

    always_comb begin
        miss_d.valid = !miss_req;
        miss_d.addr  = {req.addr[addr_bits-1:offset_bits], {offset_bits{1'b0}}};
    end

    stage_reg #(
        .payload_t (cache_req_t)
    ) i_miss_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (miss_en),
        .d_valid (miss_d.valid),
        .d       (miss_d),
        .q_valid (miss_req),
        .q       (miss_q)
    );

    assign miss_addr = miss_q.addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            line_valid <= '0;
        end else if (fill_we) begin
            line_valid[fill_idx] <= 1'b1;
        end
    end

    // fill wins over a writeback in the same cycle
    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[fill_idx]  <= miss_addr[addr_bits-1 -: tag_bits];
            data_mem[fill_idx] <= fill_data;
        end else if (wb_hit) begin
            data_mem[wb_idx] <= wb.data; // update in place, no allocate
        end
    end

    miss_addr_held: assert property (@(posedge clk) disable iff (!rst_n)
        miss_req |=> $stable(miss_addr))
        else $error("miss_addr changed during an open miss");

    // a fill lands while the missed request is still presented and missing
    fill_only_on_miss: assert property (@(posedge clk) disable iff (!rst_n)
        fill_we |-> (req.valid && !hit))
        else $error("cache line written without a pending miss");

endmodule

`default_nettype wire

// File: design/operand_swap.sv
`timescale 1ns/10ps
`default_nettype none

module operand_swap (
    input  wire mem_stage_pkg::uop_t                 uop,
    input  wire [mem_stage_pkg::data_bits-1:0]       mem_data,
    input  wire mem_stage_pkg::size_t                size,
    output mem_stage_pkg::ops_t                      ops
);
    import mem_stage_pkg::*;

    logic [data_bits-1:0] mem_masked;
    logic [data_bits-1:0] seg_ext   [op_count];
    logic [data_bits-1:0] eip_ext;
    logic [data_bits-1:0] imm_ext;

    assign mem_masked = mask_to_size(mem_data, size);
    assign eip_ext    = {{(data_bits-eip_bits){1'b0}}, uop.eip};
    assign imm_ext    = {{(data_bits-imm_bits){uop.imm[imm_bits-1]}}, uop.imm}; // sign extend

    always_comb begin
        for (int s = 0; s < op_count; s++) begin
            seg_ext[s] = {{(data_bits-seg_bits){1'b0}}, uop.segs[s]};
        end
    end

    // one selector per operand slot
    always_comb begin
        for (int i = 0; i < op_count; i++) begin
            case (uop.src[i]) inside
                [src_reg0:src_reg3]: begin
                    ops[i] = uop.regs[uop.src[i][1:0]];
                end
                [src_seg0:src_seg3]: begin
                    ops[i] = seg_ext[uop.src[i][1:0]];
                end
                src_mem: begin
                    ops[i] = mem_masked;
                end
                src_eip: begin
                    ops[i] = eip_ext;
                end
                src_imm: begin
                    ops[i] = imm_ext;
                end
                default: begin
                    ops[i] = '0; // unused source code
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/mem_merge.sv
`timescale 1ns/10ps
`default_nettype none

module mem_merge (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  in_valid,
    input  wire mem_stage_pkg::uop_t             in_uop,
    input  wire                                  fwd_stall,
    input  wire                                  hit,
    input  wire [mem_stage_pkg::data_bits-1:0]   rd_data,
    input  wire mem_stage_pkg::ops_t             ops,
    output mem_stage_pkg::cache_req_t            cache_req,
    output mem_stage_pkg::size_t                 size,
    output logic                                 stall,
    output logic                                 out_valid,
    output mem_stage_pkg::stage_out_t            out
);
    import mem_stage_pkg::*;

    stage_out_t next_out;
    stage_out_t reg_d;
    logic       reg_en;

    always_comb begin
        case (in_uop.size_ovr)
            4'b0001: size = size_byte;
            4'b0010: size = size_word;
            4'b0100: size = size_dword;
            4'b1000: size = size_qword;
            default: size = in_uop.opsize; // no override
        endcase
    end

    always_comb begin
        cache_req.addr  = in_uop.mem_addr;
        cache_req.valid = in_valid && in_uop.mem_rd;
    end

    assign stall = fwd_stall || (cache_req.valid && !hit);

    always_comb begin
        next_out.ops      = ops;
        next_out.size     = size;
        next_out.mem_data = mask_to_size(rd_data, size);
        next_out.ctrl     = in_uop.ctrl;
    end

    // a stall drops valid but keeps the last payload on out
    assign reg_d  = stall ? out : next_out;
    assign reg_en = !stall || out_valid; // idle once already emptied

    stage_reg #(
        .payload_t (stage_out_t)
    ) i_out_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (reg_en),
        .d_valid (in_valid && !stall),
        .d       (reg_d),
        .q_valid (out_valid),
        .q       (out)
    );

    size_ovr_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> $onehot0(in_uop.size_ovr))
        else $error("size_ovr has more than one bit set");

    // upstream must replay the same micro-op until the stage accepts it
    uop_held_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (stall && in_valid) |=> (in_valid && $stable(in_uop)))
        else $error("in_uop changed while the stage was stalled");

endmodule

`default_nettype wire

// File: design/mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  in_valid,
    input  wire mem_stage_pkg::uop_t             in_uop,
    input  wire                                  fwd_stall,
    input  wire mem_stage_pkg::wb_t              wb,
    input  wire                                  fill_valid,
    input  wire [mem_stage_pkg::data_bits-1:0]   fill_data,
    output logic                                 stall,
    output logic                                 out_valid,
    output mem_stage_pkg::stage_out_t            out,
    output logic                                 miss_req,
    output logic [mem_stage_pkg::addr_bits-1:0]  miss_addr
);
    import mem_stage_pkg::*;

    cache_req_t           cache_req;
    logic                 hit;
    logic [data_bits-1:0] rd_data;
    size_t                size;
    ops_t                 ops;

    dcache_read i_dcache (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (cache_req),
        .wb         (wb),
        .fill_valid (fill_valid),
        .fill_data  (fill_data),
        .hit        (hit),
        .rd_data    (rd_data),
        .miss_req   (miss_req),
        .miss_addr  (miss_addr)
    );

    operand_swap i_swap (
        .uop      (in_uop),
        .mem_data (rd_data),
        .size     (size),
        .ops      (ops)
    );

    mem_merge i_merge (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_uop    (in_uop),
        .fwd_stall (fwd_stall),
        .hit       (hit),
        .rd_data   (rd_data),
        .ops       (ops),
        .cache_req (cache_req),
        .size      (size),
        .stall     (stall),
        .out_valid (out_valid),
        .out       (out)
    );

endmodule

`default_nettype wire

// File: bench/tb_mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_stage;
    import mem_stage_pkg::*;

    localparam int          clk_period = 8;
    localparam int          test_count = 6;
    localparam logic [31:0] addr_a     = 32'h0001_2348; // line 9
    localparam logic [31:0] addr_b     = 32'h0004_5670; // line 14

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    uop_t                 in_uop;
    logic                 fwd_stall;
    wb_t                  wb;
    logic                 fill_valid;
    logic [data_bits-1:0] fill_data;
    logic                 stall;
    logic                 out_valid;
    stage_out_t           out;
    logic                 miss_req;
    logic [addr_bits-1:0] miss_addr;

    integer      seed = 32'h66133339;
    int          err_count;
    int          failed_tests;
    int          op_seq;
    logic        expect_miss;
    logic        expect_hit;
    logic        check_pending;
    logic        exp_mem_chk;
    logic        have_out;
    stage_out_t  exp_q;
    logic [63:0] shadow [logic [31:0]]; // writeback values of cached words
    logic        cached [logic [31:0]];

    initial clk = 1'b0;
    always #(clk_period/2) clk = ~clk;

    mem_stage i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_uop     (in_uop),
        .fwd_stall  (fwd_stall),
        .wb         (wb),
        .fill_valid (fill_valid),
        .fill_data  (fill_data),
        .stall      (stall),
        .out_valid  (out_valid),
        .out        (out),
        .miss_req   (miss_req),
        .miss_addr  (miss_addr)
    );

    function automatic logic [63:0] mem_word(input logic [31:0] addr);
        return {addr, addr} ^ 64'h5a5a_c3c3_0f0f_9696;
    endfunction

    function automatic logic [31:0] word_addr(input logic [31:0] addr);
        return {addr[31:3], 3'b000};
    endfunction

    function automatic logic [63:0] expected_word(input logic [31:0] addr);
        if (shadow.exists(word_addr(addr))) begin
            return shadow[word_addr(addr)];
        end
        return mem_word(word_addr(addr));
    endfunction

    function automatic size_t resolve_size(input uop_t u);
        size_t s;
        s = u.opsize;
        for (int b = 0; b < 4; b++) begin
            if (u.size_ovr[b]) begin
                s = size_t'(b);
            end
        end
        return s;
    endfunction

    function automatic logic [63:0] keep_low_bytes(input logic [63:0] data, input size_t s);
        if (s == size_qword) begin
            return data;
        end
        return data & ((64'd1 << (8 << s)) - 64'd1); // 1, 2 or 4 bytes
    endfunction

    function automatic logic [63:0] pick_source(
        input uop_t        u,
        input src_t        code,
        input logic [63:0] mem_val
    );
        logic [63:0] v;
        v = '0;
        if (code <= 4'd3) begin
            v = u.regs[code[1:0]];
        end else if (code <= 4'd7) begin
            v = {48'd0, u.segs[code[1:0]]};
        end else if (code == 4'd8) begin
            v = mem_val;
        end else if (code == 4'd9) begin
            v = {32'd0, u.eip};
        end else if (code == 4'd10) begin
            v = {{16{u.imm[47]}}, u.imm};
        end
        return v;
    endfunction

    function automatic stage_out_t expected_out(input uop_t u);
        stage_out_t  e;
        logic [63:0] mem_val;
        e.size  = resolve_size(u);
        mem_val = u.mem_rd ? keep_low_bytes(expected_word(u.mem_addr), e.size) : 64'd0;
        for (int i = 0; i < 4; i++) begin
            e.ops[i] = pick_source(u, u.src[i], mem_val);
        end
        e.mem_data = mem_val;
        e.ctrl     = u.ctrl;
        return e;
    endfunction

    // expected output of the op taken at this edge
    always @(posedge clk) begin
        if (!rst_n) begin
            check_pending <= 1'b0;
            have_out      <= 1'b0;
        end else begin
            check_pending <= in_valid && !stall;
            if (in_valid && !stall) begin
                exp_q       <= expected_out(in_uop);
                exp_mem_chk <= in_uop.mem_rd;
            end
            if (check_pending) begin
                have_out <= 1'b1;
            end
        end
    end

    task automatic report_mismatch(input string sig, input logic [255:0] got,
                                   input logic [255:0] exp);
        $display("FAIL t=%0t %s got %0h expected %0h", $time, sig, got, exp);
        err_count++;
    endtask

    task automatic report_problem(input string what);
        $display("ERROR t=%0t %s", $time, what);
        err_count++;
    endtask

    reset_clears: assert property (@(posedge clk) $past(!rst_n) |-> (!out_valid && !miss_req))
        else report_problem("out_valid or miss_req high during or right after reset");

    out_valid_seen: assert property (@(posedge clk) disable iff (!rst_n)
        check_pending |-> out_valid)
        else report_problem("accepted op did not raise out_valid one edge later");

    ops_match: assert property (@(posedge clk) disable iff (!rst_n)
        check_pending |-> (out.ops == exp_q.ops))
        else report_mismatch("out.ops", 256'(out.ops), 256'(exp_q.ops));

    size_match: assert property (@(posedge clk) disable iff (!rst_n)
        check_pending |-> (out.size == exp_q.size))
        else report_mismatch("out.size", 256'(out.size), 256'(exp_q.size));

    mem_match: assert property (@(posedge clk) disable iff (!rst_n)
        (check_pending && exp_mem_chk) |-> (out.mem_data == exp_q.mem_data))
        else report_mismatch("out.mem_data", 256'(out.mem_data), 256'(exp_q.mem_data));

    ctrl_match: assert property (@(posedge clk) disable iff (!rst_n)
        check_pending |-> (out.ctrl == exp_q.ctrl))
        else report_mismatch("out.ctrl", 256'(out.ctrl), 256'(exp_q.ctrl));

    miss_raised: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && expect_miss && op_seq != $past(op_seq)) |=> miss_req)
        else report_problem("first read of an address did not raise miss_req");

    miss_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(miss_req) |-> (miss_addr == {in_uop.mem_addr[31:3], 3'b000}))
        else report_mismatch("miss_addr", 256'(miss_addr),
                             256'({in_uop.mem_addr[31:3], 3'b000}));

    miss_stalls: assert property (@(posedge clk) disable iff (!rst_n) miss_req |-> stall)
        else report_problem("stall low while a miss is open");

    hit_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && expect_hit) |-> !stall)
        else report_problem("read of a cached word raised stall");

    fwd_forces_stall: assert property (@(posedge clk) disable iff (!rst_n) fwd_stall |-> stall)
        else report_problem("fwd_stall high but stall low");

    stall_holds_out: assert property (@(posedge clk) disable iff (!rst_n)
        (stall && have_out) |=> (!out_valid && $stable(out)))
        else report_problem("out changed or stayed valid across a stall");

    // memory answers an open miss after 2 to 6 cycles
    initial begin
        logic [31:0] rnd;
        int          wait_cycles;
        fill_valid = 1'b0;
        fill_data  = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && miss_req) begin
                rnd         = $random(seed);
                wait_cycles = 2 + int'(rnd[7:0] % 8'd5);
                repeat (wait_cycles - 1) @(posedge clk);
                #1;
                fill_valid = 1'b1;
                fill_data  = mem_word(miss_addr);
                @(posedge clk);
                #1;
                fill_valid = 1'b0;
            end
        end
    end

    task automatic make_random_uop(output uop_t u);
        for (int i = 0; i < 4; i++) begin
            u.regs[i] = {$random(seed), $random(seed)};
            u.segs[i] = 16'($random(seed));
            u.src[i]  = src_t'($random(seed));
            if (u.src[i] == src_mem) begin
                u.src[i] = 4'd12; // no load in this op
            end
        end
        u.mem_addr = $random(seed);
        u.mem_rd   = 1'b0;
        u.eip      = $random(seed);
        u.imm      = {16'($random(seed)), 32'($random(seed))};
        u.opsize   = size_t'($random(seed));
        u.size_ovr = 4'd0;
        u.ctrl     = 16'($random(seed));
    endtask

    task automatic make_load(output uop_t u, input logic [31:0] addr, input size_t opsize,
                             input logic [3:0] ovr);
        make_random_uop(u);
        u.mem_rd   = 1'b1;
        u.mem_addr = addr;
        u.src[1]   = src_mem;
        u.opsize   = opsize;
        u.size_ovr = ovr;
    endtask

    task automatic present_op(input uop_t u);
        in_valid = 1'b1;
        in_uop   = u;
        op_seq++;
    endtask

    task automatic wait_accept();
        logic took;
        took = 1'b0;
        while (!took) begin
            @(negedge clk);
            took = !stall;
            @(posedge clk);
            #1;
        end
        if (in_uop.mem_rd) begin
            cached[word_addr(in_uop.mem_addr)] = 1'b1;
        end
        in_valid = 1'b0;
    endtask

    task automatic send_op(input uop_t u);
        present_op(u);
        wait_accept();
    endtask

    task automatic send_wb(input logic [31:0] addr, input logic [63:0] data);
        wb.addr  = addr;
        wb.data  = data;
        wb.valid = 1'b1;
        if (cached.exists(word_addr(addr))) begin
            shadow[word_addr(addr)] = data;
        end
        @(posedge clk);
        #1;
        wb.valid = 1'b0;
    endtask

    task automatic end_test(input int num, input string name, input int errs_before);
        @(posedge clk);
        #1;
        if (err_count == errs_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, err_count - errs_before);
            failed_tests++;
        end
    endtask

    initial begin
        uop_t u;
        int   errs;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_uop       = '0;
        fwd_stall    = 1'b0;
        wb           = '0;
        expect_miss  = 1'b0;
        expect_hit   = 1'b0;
        op_seq       = 0;
        err_count    = 0;
        failed_tests = 0;
        errs         = 0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        end_test(1, "reset", errs);

        errs = err_count;
        for (int n = 0; n < 20; n++) begin
            make_random_uop(u);
            send_op(u);
        end
        end_test(2, "register ops", errs);

        errs = err_count;
        make_load(u, addr_a | 32'h5, size_qword, 4'd0); // low bits ignored
        expect_miss = 1'b1;
        send_op(u);
        expect_miss = 1'b0;
        make_load(u, addr_a, size_dword, 4'd0);
        expect_hit = 1'b1;
        send_op(u);
        expect_hit = 1'b0;
        end_test(3, "miss then hit", errs);

        errs = err_count;
        expect_hit = 1'b1;
        for (int b = 0; b < 4; b++) begin
            make_load(u, addr_a, size_t'(3 - b), 4'b0001 << b);
            send_op(u);
        end
        for (int s = 0; s < 4; s++) begin
            make_load(u, addr_a, size_t'(s), 4'd0);
            send_op(u);
        end
        expect_hit = 1'b0;
        end_test(4, "size override", errs);

        errs = err_count;
        send_wb(addr_a, 64'hfeed_0123_4567_89ab);
        make_load(u, addr_a, size_qword, 4'd0);
        expect_hit = 1'b1;
        send_op(u);
        expect_hit = 1'b0;
        send_wb(addr_b, 64'h1111_2222_3333_4444); // line not present, dropped
        make_load(u, addr_b, size_qword, 4'd0);
        expect_miss = 1'b1;
        send_op(u);
        expect_miss = 1'b0;
        end_test(5, "writeback", errs);

        errs = err_count;
        make_random_uop(u);
        send_op(u);
        make_random_uop(u);
        fwd_stall = 1'b1;
        present_op(u);
        repeat (3) @(posedge clk);
        #1;
        fwd_stall = 1'b0;
        wait_accept();
        end_test(6, "back-pressure", errs);

        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, err_count);
        if (err_count == 0 && failed_tests == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(test_count * 200 * clk_period);
        $display("watchdog: simulation ran past its time limit");
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
design/mem_stage_pkg.sv
design/stage_reg.sv
design/dcache_read.sv
design/operand_swap.sv
design/mem_merge.sv
design/mem_stage.sv
bench/tb_mem_stage.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mem_stage
FILELIST  = sources.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check for the pass line"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
